/* hdl/isa_pkg.sv */
package isa_pkg;

  // major opcodes
  localparam logic [5:0] OP_ALU  = 6'b100000; // register-register, uses sub_opcode
  localparam logic [5:0] OP_ADDI = 6'b101000;
  localparam logic [5:0] OP_ANDI = 6'b101100;
  localparam logic [5:0] OP_ORI  = 6'b101101;
  localparam logic [5:0] OP_XORI = 6'b101110;
  localparam logic [5:0] OP_MOVI = 6'b100010; // src2 passes straight through

  // sub-opcodes under OP_ALU
  localparam logic [4:0] SUB_ADD = 5'd0;
  localparam logic [4:0] SUB_SUB = 5'd1;
  localparam logic [4:0] SUB_AND = 5'd2;
  localparam logic [4:0] SUB_OR  = 5'd3;
  localparam logic [4:0] SUB_XOR = 5'd4;
  localparam logic [4:0] SUB_NOR = 5'd5;
  localparam logic [4:0] SUB_SLT = 5'd6;  // signed compare
  localparam logic [4:0] SUB_SLL = 5'd8;
  localparam logic [4:0] SUB_SRL = 5'd9;
  localparam logic [4:0] SUB_SRA = 5'd10;

  typedef enum logic [1:0] {
    IMM5_ZE  = 2'b00,
    IMM15_SE = 2'b01,
    IMM15_ZE = 2'b10,
    IMM20_SE = 2'b11
  } imm_kind_e;

  // one 20-bit immediate word, read three ways
  typedef union packed {
    logic [19:0] imm20;
    struct packed {
      logic [4:0]  pad;
      logic [14:0] imm;
    } i15;
    struct packed {
      logic [14:0] pad;
      logic [4:0]  imm;
    } i5;
  } imm_field_u;

endpackage

/* hdl/dp_pkg.sv */
package dp_pkg;

  // writeback source
  typedef enum logic {
    WB_ALU  = 1'b0,
    WB_OPND = 1'b1  // second operand for moves
  } wb_sel_e;

  // second operand source
  localparam logic OPND_REG = 1'b0;
  localparam logic OPND_IMM = 1'b1;

  // controller drives all of this as levels or single-cycle strobes
  typedef struct packed {
    logic                fetch;      // strobe to latch rd1/rd2
    logic                execute;    // strobe to latch the alu result
    logic                writeback;  // strobe to write wa
    isa_pkg::imm_kind_e  imm_kind;
    logic                use_imm;    // OPND_REG or OPND_IMM
    wb_sel_e             wb_sel;
    logic [5:0]          opcode;
    logic [4:0]          sub_opcode;
    logic                pad;
  } dp_ctrl_t;

endpackage

/* hdl/regfile.sv */
`timescale 1ns/10ps

module regfile #(
  parameter int DATA_W = 32,
  parameter int ADDR_W = 5
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              fetch,
  input  logic              writeback,
  input  logic [ADDR_W-1:0] ra1,
  input  logic [ADDR_W-1:0] ra2,
  input  logic [ADDR_W-1:0] wa,
  input  logic [DATA_W-1:0] wdata,
  output logic [DATA_W-1:0] rd1,
  output logic [DATA_W-1:0] rd2
);

  localparam int DEPTH = 2 ** ADDR_W;

  logic [DATA_W-1:0] regs [DEPTH];

  // write port
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        regs[i] <= '0;
      end
    end else if (writeback) begin
      regs[wa] <= wdata;
    end
  end

  // read ports, old data on a same-cycle write
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd1 <= '0;
      rd2 <= '0;
    end else if (fetch) begin
      rd1 <= regs[ra1];
      rd2 <= regs[ra2];
    end
  end

  // writeback data comes from the top-level mux, so catch X from there
  assert property (
    @(posedge clk) disable iff (!arst_n)
    writeback |-> !$isunknown({wa, wdata})
  ) else $error("regfile: unknown write address or data on writeback");

endmodule

/* hdl/imm_gen.sv */
`timescale 1ns/10ps

module imm_gen #(
  parameter int DATA_W = 32
) (
  input  isa_pkg::imm_field_u imm,
  input  isa_pkg::imm_kind_e  kind,
  output logic [DATA_W-1:0]   imm_ext
);

  logic sign15;
  logic sign20;

  assign sign15 = imm.i15.imm[14];
  assign sign20 = imm.imm20[19];

  always_comb begin
    case (kind)
      isa_pkg::IMM5_ZE: begin
        imm_ext = {{(DATA_W-5){1'b0}}, imm.i5.imm};
      end
      isa_pkg::IMM15_SE: begin
        imm_ext = {{(DATA_W-15){sign15}}, imm.i15.imm};
      end
      isa_pkg::IMM15_ZE: begin
        imm_ext = {{(DATA_W-15){1'b0}}, imm.i15.imm};
      end
      isa_pkg::IMM20_SE: begin
        imm_ext = {{(DATA_W-20){sign20}}, imm.imm20};
      end
      default: begin
        imm_ext = '0; // unreachable, all four kinds decoded
      end
    endcase
  end

endmodule

/* hdl/alu32.sv */
`timescale 1ns/10ps

module alu32 #(
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              execute,
  input  logic [5:0]        opcode,
  input  logic [4:0]        sub_opcode,
  input  logic [DATA_W-1:0] src1,
  input  logic [DATA_W-1:0] src2,
  output logic [DATA_W-1:0] alu_result,
  output logic              alu_overflow
);

  localparam int SHAMT_W = $clog2(DATA_W);

  logic [DATA_W-1:0]  sum;
  logic [DATA_W-1:0]  diff;
  logic               add_ovf;
  logic               sub_ovf;
  logic               slt;
  logic [SHAMT_W-1:0] shamt;
  logic [DATA_W-1:0]  next_result;
  logic               next_ovf;
  logic               op_valid;

  assign sum   = src1 + src2;
  assign diff  = src1 - src2;
  assign shamt = src2[SHAMT_W-1:0]; // low bits only
  assign slt   = $signed(src1) < $signed(src2);

  // signed wrap: result sign differs from what the operands allow
  assign add_ovf = (src1[DATA_W-1] == src2[DATA_W-1]) &&
                   (sum[DATA_W-1] != src1[DATA_W-1]);
  assign sub_ovf = (src1[DATA_W-1] != src2[DATA_W-1]) &&
                   (diff[DATA_W-1] != src1[DATA_W-1]);

  always_comb begin
    next_result = '0;
    next_ovf    = 1'b0;
    op_valid    = 1'b1;
    case (opcode)
      isa_pkg::OP_ALU: begin
        case (sub_opcode)
          isa_pkg::SUB_ADD: begin
            next_result = sum;
            next_ovf    = add_ovf;
          end
          isa_pkg::SUB_SUB: begin
            next_result = diff;
            next_ovf    = sub_ovf;
          end
          isa_pkg::SUB_AND: next_result = src1 & src2;
          isa_pkg::SUB_OR:  next_result = src1 | src2;
          isa_pkg::SUB_XOR: next_result = src1 ^ src2;
          isa_pkg::SUB_NOR: next_result = ~(src1 | src2);
          isa_pkg::SUB_SLT: next_result = {{(DATA_W-1){1'b0}}, slt};
          isa_pkg::SUB_SLL: next_result = src1 << shamt;
          isa_pkg::SUB_SRL: next_result = src1 >> shamt;
          isa_pkg::SUB_SRA: next_result = $signed(src1) >>> shamt;
          default:          op_valid    = 1'b0;
        endcase
      end
      isa_pkg::OP_ADDI: begin
        next_result = sum;
        next_ovf    = add_ovf;
      end
      isa_pkg::OP_ANDI: next_result = src1 & src2;
      isa_pkg::OP_ORI:  next_result = src1 | src2;
      isa_pkg::OP_XORI: next_result = src1 ^ src2;
      isa_pkg::OP_MOVI: next_result = src2;
      default:          op_valid    = 1'b0; // result stays zero
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      alu_result   <= '0;
      alu_overflow <= 1'b0;
    end else if (execute) begin
      alu_result   <= next_result;
      alu_overflow <= next_ovf;
    end
  end

  // controller should never issue an undefined operation
  assert property (
    @(posedge clk) disable iff (!arst_n)
    execute |-> op_valid
  ) else $error("alu32: execute with undefined opcode %0h / sub-opcode %0h",
                opcode, sub_opcode);

endmodule

/* hdl/exec_datapath.sv */
`timescale 1ns/10ps

module exec_datapath #(
  parameter int DATA_W = 32,
  parameter int ADDR_W = 5
) (
  input  logic                clk,
  input  logic                arst_n,
  input  dp_pkg::dp_ctrl_t    ctrl,
  input  logic [ADDR_W-1:0]   ra1,
  input  logic [ADDR_W-1:0]   ra2,
  input  logic [ADDR_W-1:0]   wa,
  input  isa_pkg::imm_field_u imm,
  output logic [DATA_W-1:0]   alu_result,
  output logic                alu_overflow
);

  logic [DATA_W-1:0] rd1;
  logic [DATA_W-1:0] rd2;
  logic [DATA_W-1:0] imm_ext;
  logic [DATA_W-1:0] src2;
  logic [DATA_W-1:0] wdata;

  regfile #(
    .DATA_W (DATA_W),
    .ADDR_W (ADDR_W)
  ) i_regfile (
    .clk       (clk),
    .arst_n    (arst_n),
    .fetch     (ctrl.fetch),
    .writeback (ctrl.writeback),
    .ra1       (ra1),
    .ra2       (ra2),
    .wa        (wa),
    .wdata     (wdata),
    .rd1       (rd1),
    .rd2       (rd2)
  );

  imm_gen #(
    .DATA_W (DATA_W)
  ) i_imm_gen (
    .imm     (imm),
    .kind    (ctrl.imm_kind),
    .imm_ext (imm_ext)
  );

  // operand select
  assign src2 = (ctrl.use_imm == dp_pkg::OPND_IMM) ? imm_ext : rd2;

  alu32 #(
    .DATA_W (DATA_W)
  ) i_alu (
    .clk          (clk),
    .arst_n       (arst_n),
    .execute      (ctrl.execute),
    .opcode       (ctrl.opcode),
    .sub_opcode   (ctrl.sub_opcode),
    .src1         (rd1),
    .src2         (src2),
    .alu_result   (alu_result),
    .alu_overflow (alu_overflow)
  );

  // writeback select, honoured on the write port
  assign wdata = (ctrl.wb_sel == dp_pkg::WB_OPND) ? src2 : alu_result;

endmodule

/* verif/tb_exec_datapath.sv */
`timescale 1ns/10ps

module tb_exec_datapath;

  localparam int DATA_W        = 32;
  localparam int ADDR_W        = 5;
  localparam int N_RAND        = 300;
  localparam int CYC_PER_INSTR = 5;                 // fetch, execute, writeback, idle, margin
  localparam int N_INSTR       = 3 * N_RAND + 200;  // directed plus random, with readbacks
  localparam int WATCHDOG_NS   = (N_INSTR * CYC_PER_INSTR + 10) * 8 + 2000;

  logic                clk = 1'b0;
  logic                arst_n;
  dp_pkg::dp_ctrl_t    ctrl;
  logic [ADDR_W-1:0]   ra1;
  logic [ADDR_W-1:0]   ra2;
  logic [ADDR_W-1:0]   wa;
  isa_pkg::imm_field_u imm;
  logic [DATA_W-1:0]   alu_result;
  logic                alu_overflow;

  logic [DATA_W-1:0] model_regs [32];
  logic [DATA_W-1:0] last_result;
  logic              last_ovf;
  integer            seed;
  int                errors;
  int                checks;

  logic [4:0]  sub_list [10] = '{isa_pkg::SUB_ADD, isa_pkg::SUB_SUB, isa_pkg::SUB_AND,
                                 isa_pkg::SUB_OR, isa_pkg::SUB_XOR, isa_pkg::SUB_NOR,
                                 isa_pkg::SUB_SLT, isa_pkg::SUB_SLL, isa_pkg::SUB_SRL,
                                 isa_pkg::SUB_SRA};
  logic [5:0]  imm_ops [5] = '{isa_pkg::OP_ADDI, isa_pkg::OP_ANDI, isa_pkg::OP_ORI,
                               isa_pkg::OP_XORI, isa_pkg::OP_MOVI};
  logic [19:0] lim_imm [3] = '{20'h7ffff, 20'h80000, 20'h04000};

  exec_datapath #(
    .DATA_W (DATA_W),
    .ADDR_W (ADDR_W)
  ) i_dut (
    .clk          (clk),
    .arst_n       (arst_n),
    .ctrl         (ctrl),
    .ra1          (ra1),
    .ra2          (ra2),
    .wa           (wa),
    .imm          (imm),
    .alu_result   (alu_result),
    .alu_overflow (alu_overflow)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] next_rand();
    return $random(seed);
  endfunction

  // write address 1..31, register 0 stays zero for readbacks
  function automatic logic [4:0] pick_wa(input logic [31:0] r);
    logic [31:0] t;
    t = (r % 32'd31) + 32'd1;
    return t[4:0];
  endfunction

  function automatic logic [31:0] model_ext(input logic [19:0] f, input isa_pkg::imm_kind_e kind);
    case (kind)
      isa_pkg::IMM5_ZE:  return {27'b0, f[4:0]};
      isa_pkg::IMM15_SE: return {{17{f[14]}}, f[14:0]};
      isa_pkg::IMM15_ZE: return {17'b0, f[14:0]};
      default:           return {{12{f[19]}}, f};
    endcase
  endfunction

  // returns {overflow, result}
  function automatic logic [32:0] model_alu(input logic [5:0] op, input logic [4:0] sub,
                                            input logic [31:0] a, input logic [31:0] b);
    logic signed [63:0] wide;
    logic [31:0]        r;
    logic               ovf;
    r    = '0;
    ovf  = 1'b0;
    wide = '0;
    if (op == isa_pkg::OP_ADDI || (op == isa_pkg::OP_ALU && sub == isa_pkg::SUB_ADD)) begin
      wide = 64'($signed(a)) + 64'($signed(b));
    end else if (op == isa_pkg::OP_ALU && sub == isa_pkg::SUB_SUB) begin
      wide = 64'($signed(a)) - 64'($signed(b));
    end
    if (op == isa_pkg::OP_ALU) begin
      case (sub)
        isa_pkg::SUB_ADD, isa_pkg::SUB_SUB: begin
          r   = wide[31:0];
          ovf = (wide > 64'sh7fffffff) || (wide < -64'sh80000000);
        end
        isa_pkg::SUB_AND: r = a & b;
        isa_pkg::SUB_OR:  r = a | b;
        isa_pkg::SUB_XOR: r = a ^ b;
        isa_pkg::SUB_NOR: r = ~(a | b);
        isa_pkg::SUB_SLT: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        isa_pkg::SUB_SLL: r = a << b[4:0];
        isa_pkg::SUB_SRL: r = a >> b[4:0];
        isa_pkg::SUB_SRA: r = 32'($signed(a) >>> b[4:0]);
        default:          r = '0;
      endcase
    end else if (op == isa_pkg::OP_ADDI) begin
      r   = wide[31:0];
      ovf = (wide > 64'sh7fffffff) || (wide < -64'sh80000000);
    end else if (op == isa_pkg::OP_ANDI) begin
      r = a & b;
    end else if (op == isa_pkg::OP_ORI) begin
      r = a | b;
    end else if (op == isa_pkg::OP_XORI) begin
      r = a ^ b;
    end else if (op == isa_pkg::OP_MOVI) begin
      r = b;
    end
    return {ovf, r};
  endfunction

  task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  // one instruction, strictly sequential: fetch, execute, writeback, idle
  task automatic run_instr(input logic [5:0] op, input logic [4:0] sub, input logic use_i,
                           input isa_pkg::imm_kind_e kind, input logic [19:0] f,
                           input logic [4:0] a1, input logic [4:0] a2, input logic do_wb,
                           input dp_pkg::wb_sel_e sel, input logic [4:0] w);
    dp_pkg::dp_ctrl_t c;
    logic [31:0]      src2;
    logic [32:0]      expected;
    c            = '0;
    c.fetch      = 1'b1;
    c.imm_kind   = kind;
    c.use_imm    = use_i;
    c.wb_sel     = sel;
    c.opcode     = op;
    c.sub_opcode = sub;
    src2     = use_i ? model_ext(f, kind) : model_regs[a2];
    expected = model_alu(op, sub, model_regs[a1], src2);
    @(posedge clk);
    ctrl <= c;
    ra1  <= a1;
    ra2  <= a2;
    wa   <= w;
    imm  <= f;
    @(posedge clk);
    c.fetch   = 1'b0;
    c.execute = 1'b1;
    ctrl <= c;
    @(posedge clk);
    c.execute   = 1'b0;
    c.writeback = do_wb;
    ctrl <= c;
    @(negedge clk);
    check("alu_result", expected[31:0], alu_result);
    check("alu_overflow", {31'b0, expected[32]}, {31'b0, alu_overflow});
    last_result = expected[31:0];
    last_ovf    = expected[32];
    @(posedge clk);
    c.writeback = 1'b0;
    ctrl <= c;
    if (do_wb) begin
      model_regs[w] = (sel == dp_pkg::WB_OPND) ? src2 : expected[31:0];
    end
  endtask

  // read a register back through an OR with register 0
  task automatic read_back(input logic [4:0] r);
    run_instr(isa_pkg::OP_ALU, isa_pkg::SUB_OR, 1'b0, isa_pkg::IMM5_ZE, 20'h0, r, 5'd0,
              1'b0, dp_pkg::WB_ALU, 5'd1);
  endtask

  // new operands fetched, execute stays low
  task automatic hold_check();
    dp_pkg::dp_ctrl_t c;
    logic [31:0]      r;
    c        = '0;
    c.fetch  = 1'b1;
    c.opcode = isa_pkg::OP_ALU;
    r        = next_rand();
    @(posedge clk);
    ctrl <= c;
    ra1  <= r[4:0];
    ra2  <= r[9:5];
    imm  <= r[31:12];
    @(posedge clk);
    ctrl <= '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check("alu_result (held)", last_result, alu_result);
    check("alu_overflow (held)", {31'b0, last_ovf}, {31'b0, alu_overflow});
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog: simulation did not finish in %0d ns", WATCHDOG_NS);
    $display("Checks failed");
    $finish;
  end

  initial begin
    logic [31:0] rnd;
    logic [31:0] rnd2;
    logic [4:0]  w;
    seed        = 32'h1eea;
    errors      = 0;
    checks      = 0;
    last_result = '0;
    last_ovf    = 1'b0;
    arst_n <= 1'b0;
    ctrl   <= '0;
    ra1    <= '0;
    ra2    <= '0;
    wa     <= '0;
    imm    <= '0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check("alu_result after reset", 32'h0, alu_result);
    check("alu_overflow after reset", 32'h0, {31'b0, alu_overflow});
    run_instr(isa_pkg::OP_ALU, isa_pkg::SUB_OR, 1'b0, isa_pkg::IMM5_ZE, 20'h0, 5'd0, 5'd1,
              1'b0, dp_pkg::WB_ALU, 5'd1);

    // fill the register file through the operand writeback path
    for (int i = 1; i < 32; i++) begin
      rnd = next_rand();
      run_instr(isa_pkg::OP_MOVI, isa_pkg::SUB_ADD, 1'b1, isa_pkg::IMM20_SE, rnd[19:0],
                5'd0, 5'd0, 1'b1, dp_pkg::WB_OPND, 5'(i));
      read_back(5'(i));
    end

    // limit values: r1 = 0x80000000, r2 = 0x7fffffff, r3 = -1, r4 = 1
    run_instr(isa_pkg::OP_MOVI, isa_pkg::SUB_ADD, 1'b1, isa_pkg::IMM5_ZE, 20'h1, 5'd0, 5'd0,
              1'b1, dp_pkg::WB_OPND, 5'd1);
    run_instr(isa_pkg::OP_ALU, isa_pkg::SUB_SLL, 1'b1, isa_pkg::IMM5_ZE, 20'h1f, 5'd1, 5'd0,
              1'b1, dp_pkg::WB_ALU, 5'd1);
    run_instr(isa_pkg::OP_ALU, isa_pkg::SUB_NOR, 1'b0, isa_pkg::IMM5_ZE, 20'h0, 5'd1, 5'd0,
              1'b1, dp_pkg::WB_ALU, 5'd2);
    run_instr(isa_pkg::OP_MOVI, isa_pkg::SUB_ADD, 1'b1, isa_pkg::IMM20_SE, 20'hfffff, 5'd0,
              5'd0, 1'b1, dp_pkg::WB_OPND, 5'd3);
    run_instr(isa_pkg::OP_MOVI, isa_pkg::SUB_ADD, 1'b1, isa_pkg::IMM5_ZE, 20'h1, 5'd0, 5'd0,
              1'b1, dp_pkg::WB_OPND, 5'd4);
    for (int a = 1; a <= 4; a++) begin
      for (int b = 1; b <= 4; b++) begin
        run_instr(isa_pkg::OP_ALU, isa_pkg::SUB_ADD, 1'b0, isa_pkg::IMM5_ZE, 20'h0, 5'(a),
                  5'(b), 1'b0, dp_pkg::WB_ALU, 5'd1);
        run_instr(isa_pkg::OP_ALU, isa_pkg::SUB_SUB, 1'b0, isa_pkg::IMM5_ZE, 20'h0, 5'(a),
                  5'(b), 1'b0, dp_pkg::WB_ALU, 5'd1);
        run_instr(isa_pkg::OP_ALU, isa_pkg::SUB_XOR, 1'b0, isa_pkg::IMM5_ZE, 20'h0, 5'(a),
                  5'(b), 1'b0, dp_pkg::WB_ALU, 5'd1); // clears the flag again
      end
      for (int k = 0; k < 3; k++) begin
        run_instr(isa_pkg::OP_ADDI, isa_pkg::SUB_ADD, 1'b1, isa_pkg::IMM20_SE, lim_imm[k],
                  5'(a), 5'd0, 1'b0, dp_pkg::WB_ALU, 5'd1);
        run_instr(isa_pkg::OP_ADDI, isa_pkg::SUB_ADD, 1'b1, isa_pkg::IMM15_SE, lim_imm[k],
                  5'(a), 5'd0, 1'b0, dp_pkg::WB_ALU, 5'd1);
      end
    end

    // every immediate opcode under every kind
    for (int o = 0; o < 5; o++) begin
      for (int k = 0; k < 4; k++) begin
        rnd = next_rand();
        run_instr(imm_ops[o], isa_pkg::SUB_ADD, 1'b1, isa_pkg::imm_kind_e'(k), rnd[31:12],
                  rnd[4:0], 5'd0, 1'b0, dp_pkg::WB_ALU, 5'd1);
      end
    end

    for (int n = 0; n < N_RAND; n++) begin
      rnd  = next_rand();
      rnd2 = next_rand();
      w    = pick_wa(next_rand());
      if (rnd[0]) begin
        run_instr(isa_pkg::OP_ALU, sub_list[rnd[7:4] % 4'd10], 1'b0,
                  isa_pkg::imm_kind_e'(rnd[13:12]), rnd2[31:12], rnd2[4:0], rnd2[9:5],
                  rnd[1], dp_pkg::wb_sel_e'(rnd[2]), w);
      end else begin
        run_instr(imm_ops[rnd[10:8] % 3'd5], isa_pkg::SUB_ADD, 1'b1,
                  isa_pkg::imm_kind_e'(rnd[13:12]), rnd2[31:12], rnd2[4:0], 5'd0,
                  rnd[1], dp_pkg::wb_sel_e'(rnd[2]), w);
      end
      if (rnd[1]) begin
        read_back(w);
      end
      if (n % 8 == 0) begin
        hold_check();
      end
    end

    $display("tb_exec_datapath: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* datapath.f */
hdl/isa_pkg.sv
hdl/dp_pkg.sv
hdl/regfile.sv
hdl/imm_gen.sv
hdl/alu32.sv
hdl/exec_datapath.sv
verif/tb_exec_datapath.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_exec_datapath
FILELIST  ?= datapath.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
